/* design/forwarding_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
	input  hazard_pkg::reg_addr_t id_rs_a,
	input  hazard_pkg::reg_addr_t id_rs_b,
	input  logic                  id_sel_op_a,
	input  logic                  id_sel_op_b,
	input  logic                  id_is_stype,
	input  hazard_pkg::imm_sel_t  id_imm_select,
	input  hazard_pkg::opcode_t   id_opcode,
	input  hazard_pkg::reg_addr_t exe_rs_a,
	input  hazard_pkg::reg_addr_t exe_rs_b,
	input  hazard_pkg::opcode_t   exe_opcode,
	input  hazard_pkg::reg_addr_t exe_rd,
	input  hazard_pkg::reg_addr_t mem_rd,
	input  hazard_pkg::reg_addr_t wb_rd,
	input  logic                  exe_wr_en,
	input  logic                  mem_wr_en,
	input  logic                  wb_wr_en,
	input  hazard_pkg::sel_data_t exe_sel_data,
	input  hazard_pkg::sel_data_t mem_sel_data,
	input  hazard_pkg::sel_data_t wb_sel_data,
	output logic                  fw_exe_to_id_a,
	output logic                  fw_exe_to_id_b,
	output logic                  fw_mem_to_id_a,
	output logic                  fw_mem_to_id_b,
	output logic                  fw_wb_to_id_a,
	output logic                  fw_wb_to_id_b,
	output logic                  fw_wb_to_exe_a,
	output logic                  fw_wb_to_exe_b,
	output logic                  hzd_exe_to_id_a,
	output logic                  hzd_mem_to_exe_a,
	output logic                  hzd_mem_to_exe_b
);
	import hazard_pkg::*;

	logic id_use_a, id_use_b, exe_use_a, exe_use_b;
	logic exe_match_a, exe_match_b, mem_match_a, mem_match_b, wb_match_a, wb_match_b;
	logic exe_is_load, mem_is_load, wb_is_load;

	// ID reads rs1 unless U/J immediates take its place
	assign id_use_a = id_sel_op_a && (id_imm_select != IMM_U) && (id_imm_select != IMM_J);
	// Stores still need rs2 as write data
	assign id_use_b = !id_sel_op_b || id_is_stype;

	// EXE operand use from the opcode alone
	assign exe_use_a = !(exe_opcode == OP_LUI || exe_opcode == OP_AUIPC || exe_opcode == OP_JAL);
	assign exe_use_b = exe_use_a &&
		(exe_opcode == OP_REG || exe_opcode == OP_BRANCH || exe_opcode == OP_STORE);

	assign exe_is_load = (exe_sel_data == SEL_MEM);
	assign mem_is_load = (mem_sel_data == SEL_MEM);
	assign wb_is_load  = (wb_sel_data == SEL_MEM);

	// Source nonzero, equal to producer rd, producer writing
	assign exe_match_a = (id_rs_a != '0) && (id_rs_a == exe_rd) && exe_wr_en;
	assign exe_match_b = (id_rs_b != '0) && (id_rs_b == exe_rd) && exe_wr_en;
	assign mem_match_a = (id_rs_a != '0) && (id_rs_a == mem_rd) && mem_wr_en;
	assign mem_match_b = (id_rs_b != '0) && (id_rs_b == mem_rd) && mem_wr_en;
	assign wb_match_a  = (id_rs_a != '0) && (id_rs_a == wb_rd) && wb_wr_en;
	assign wb_match_b  = (id_rs_b != '0) && (id_rs_b == wb_rd) && wb_wr_en;

	// Load data is not ready while still in EXE
	assign fw_exe_to_id_a = exe_match_a && id_use_a && !exe_is_load;
	assign fw_exe_to_id_b = exe_match_b && id_use_b && !exe_is_load;
	assign fw_mem_to_id_a = mem_match_a && id_use_a;
	assign fw_mem_to_id_b = mem_match_b && id_use_b;
	assign fw_wb_to_id_a  = wb_match_a && id_use_a;
	assign fw_wb_to_id_b  = wb_match_b && id_use_b;

	// Load result reaching EXE consumer one cycle late, after the stall
	assign fw_wb_to_exe_a = (exe_rs_a != '0) && (exe_rs_a == wb_rd) && wb_wr_en &&
		wb_is_load && exe_use_a;
	assign fw_wb_to_exe_b = (exe_rs_b != '0) && (exe_rs_b == wb_rd) && wb_wr_en &&
		wb_is_load && exe_use_b;

	// JALR target adder sits in ID, so a load in EXE must stall it
	assign hzd_exe_to_id_a = exe_match_a && exe_is_load && (id_opcode == OP_JALR);

	assign hzd_mem_to_exe_a = (exe_rs_a != '0) && (exe_rs_a == mem_rd) && mem_wr_en &&
		mem_is_load && exe_use_a;
	assign hzd_mem_to_exe_b = (exe_rs_b != '0) && (exe_rs_b == mem_rd) && mem_wr_en &&
		mem_is_load && exe_use_b;

	always_comb begin
		// A load in EXE stalls the JALR, never forwards to it
		a_fw_vs_hzd: assert (!(fw_exe_to_id_a && hzd_exe_to_id_a))
			else $error("EXE forward and load-use stall on the same operand");
	end

endmodule

`default_nettype wire

/* design/hazard_pkg.sv */
`default_nettype none

package hazard_pkg;

	// Plain vector widths with a meaning
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  sel_data_t;
	typedef logic [2:0]  imm_sel_t;
	typedef logic [31:0] instr_t;

	// Writeback source, MEM means a load
	localparam sel_data_t SEL_ALU = 3'd0;
	localparam sel_data_t SEL_PC4 = 3'd1;
	localparam sel_data_t SEL_IMM = 3'd2;
	localparam sel_data_t SEL_MEM = 3'd3;

	// Immediate formats
	localparam imm_sel_t IMM_I = 3'd0;
	localparam imm_sel_t IMM_S = 3'd1;
	localparam imm_sel_t IMM_U = 3'd2;
	localparam imm_sel_t IMM_B = 3'd3;
	localparam imm_sel_t IMM_J = 3'd4;

	// RV32I major opcodes
	localparam opcode_t OP_LUI    = 7'h37;
	localparam opcode_t OP_AUIPC  = 7'h17;
	localparam opcode_t OP_JAL    = 7'h6F;
	localparam opcode_t OP_JALR   = 7'h67;
	localparam opcode_t OP_BRANCH = 7'h63;
	localparam opcode_t OP_LOAD   = 7'h03;
	localparam opcode_t OP_STORE  = 7'h23;
	localparam opcode_t OP_IMM    = 7'h13;
	localparam opcode_t OP_REG    = 7'h33;

	// Stall kind taken in the previous cycle
	typedef enum logic [1:0] {
		RUN,
		STALL_LD_EXE,
		STALL_LD_JALR
	} stage_state_t;

endpackage

`default_nettype wire

/* design/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
	input  hazard_pkg::instr_t    instr,
	output hazard_pkg::reg_addr_t rs_a,
	output hazard_pkg::reg_addr_t rs_b,
	output hazard_pkg::reg_addr_t rd,
	output hazard_pkg::opcode_t   opcode,
	output logic                  wr_en,
	output logic                  sel_op_a,
	output logic                  sel_op_b,
	output logic                  is_stype,
	output hazard_pkg::sel_data_t sel_data,
	output hazard_pkg::imm_sel_t  imm_select
);
	import hazard_pkg::*;

	logic writes_rd;

	// Register fields sit at fixed positions in every format
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign rs_a   = instr[19:15];
	assign rs_b   = instr[24:20];

	always_comb begin
		// No-op defaults, also used for unknown opcodes
		writes_rd  = 1'b0;
		sel_op_a   = 1'b0;
		sel_op_b   = 1'b1;
		is_stype   = 1'b0;
		sel_data   = SEL_ALU;
		imm_select = IMM_I;
		case (opcode)
			OP_LUI: begin
				writes_rd  = 1'b1;
				sel_data   = SEL_IMM;
				imm_select = IMM_U;
			end
			// Operand A is the PC here
			OP_AUIPC: begin
				writes_rd  = 1'b1;
				imm_select = IMM_U;
			end
			OP_JAL: begin
				writes_rd  = 1'b1;
				sel_data   = SEL_PC4;
				imm_select = IMM_J;
			end
			OP_JALR: begin
				writes_rd = 1'b1;
				sel_op_a  = 1'b1;
				sel_data  = SEL_PC4;
			end
			// Compare rs1 against rs2, no writeback
			OP_BRANCH: begin
				sel_op_a   = 1'b1;
				sel_op_b   = 1'b0;
				imm_select = IMM_B;
			end
			OP_LOAD: begin
				writes_rd = 1'b1;
				sel_op_a  = 1'b1;
				sel_data  = SEL_MEM;
			end
			// Address from rs1 + imm, rs2 is the store data
			OP_STORE: begin
				sel_op_a   = 1'b1;
				is_stype   = 1'b1;
				imm_select = IMM_S;
			end
			OP_IMM: begin
				writes_rd = 1'b1;
				sel_op_a  = 1'b1;
			end
			OP_REG: begin
				writes_rd = 1'b1;
				sel_op_a  = 1'b1;
				sel_op_b  = 1'b0;
			end
			default: begin
			end
		endcase
	end

	// x0 is never a real destination
	assign wr_en = writes_rd && (rd != '0);

endmodule

`default_nettype wire

/* design/pipe_hazard_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_hazard_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  hazard_pkg::instr_t    in_instr,
	output logic                  in_ready,
	output logic                  fw_exe_to_id_a,
	output logic                  fw_exe_to_id_b,
	output logic                  fw_mem_to_id_a,
	output logic                  fw_mem_to_id_b,
	output logic                  fw_wb_to_id_a,
	output logic                  fw_wb_to_id_b,
	output logic                  fw_wb_to_exe_a,
	output logic                  fw_wb_to_exe_b,
	output logic                  hzd_exe_to_id_a,
	output logic                  hzd_mem_to_exe_a,
	output logic                  hzd_mem_to_exe_b,
	output logic                  retire_valid,
	output hazard_pkg::reg_addr_t retire_rd
);
	import hazard_pkg::*;

	// Decoder outputs for the word on the input port
	reg_addr_t dec_rs_a, dec_rs_b, dec_rd;
	opcode_t   dec_opcode;
	logic      dec_wr_en, dec_sel_op_a, dec_sel_op_b, dec_is_stype;
	sel_data_t dec_sel_data;
	imm_sel_t  dec_imm_select;

	// Stage fields toward the forwarding unit
	reg_addr_t id_rs_a, id_rs_b, exe_rs_a, exe_rs_b;
	reg_addr_t exe_rd, mem_rd, wb_rd;
	logic      id_sel_op_a, id_sel_op_b, id_is_stype;
	imm_sel_t  id_imm_select;
	opcode_t   id_opcode, exe_opcode;
	logic      exe_wr_en, mem_wr_en, wb_wr_en;
	sel_data_t exe_sel_data, mem_sel_data, wb_sel_data;

	inst_decode u_decode (
		.instr      (in_instr),
		.rs_a       (dec_rs_a),
		.rs_b       (dec_rs_b),
		.rd         (dec_rd),
		.opcode     (dec_opcode),
		.wr_en      (dec_wr_en),
		.sel_op_a   (dec_sel_op_a),
		.sel_op_b   (dec_sel_op_b),
		.is_stype   (dec_is_stype),
		.sel_data   (dec_sel_data),
		.imm_select (dec_imm_select)
	);

	// Port names match the local nets one to one
	stage_tracker u_tracker (
		.clk,
		.arst_n,
		.in_valid,
		.in_ready,
		.in_instr,
		.dec_rs_a,
		.dec_rs_b,
		.dec_rd,
		.dec_opcode,
		.dec_wr_en,
		.dec_sel_op_a,
		.dec_sel_op_b,
		.dec_is_stype,
		.dec_sel_data,
		.dec_imm_select,
		.hzd_exe_to_id_a,
		.hzd_mem_to_exe_a,
		.hzd_mem_to_exe_b,
		.id_rs_a,
		.id_rs_b,
		.id_sel_op_a,
		.id_sel_op_b,
		.id_is_stype,
		.id_imm_select,
		.id_opcode,
		.exe_rs_a,
		.exe_rs_b,
		.exe_opcode,
		.exe_rd,
		.mem_rd,
		.wb_rd,
		.exe_wr_en,
		.mem_wr_en,
		.wb_wr_en,
		.exe_sel_data,
		.mem_sel_data,
		.wb_sel_data,
		.retire_valid,
		.retire_rd
	);

	// Combinational, hazards loop back into the tracker
	forwarding_unit u_forward (.*);

endmodule

`default_nettype wire

/* design/stage_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_tracker (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  hazard_pkg::instr_t    in_instr,
	input  hazard_pkg::reg_addr_t dec_rs_a,
	input  hazard_pkg::reg_addr_t dec_rs_b,
	input  hazard_pkg::reg_addr_t dec_rd,
	input  hazard_pkg::opcode_t   dec_opcode,
	input  logic                  dec_wr_en,
	input  logic                  dec_sel_op_a,
	input  logic                  dec_sel_op_b,
	input  logic                  dec_is_stype,
	input  hazard_pkg::sel_data_t dec_sel_data,
	input  hazard_pkg::imm_sel_t  dec_imm_select,
	input  logic                  hzd_exe_to_id_a,
	input  logic                  hzd_mem_to_exe_a,
	input  logic                  hzd_mem_to_exe_b,
	output hazard_pkg::reg_addr_t id_rs_a,
	output hazard_pkg::reg_addr_t id_rs_b,
	output logic                  id_sel_op_a,
	output logic                  id_sel_op_b,
	output logic                  id_is_stype,
	output hazard_pkg::imm_sel_t  id_imm_select,
	output hazard_pkg::opcode_t   id_opcode,
	output hazard_pkg::reg_addr_t exe_rs_a,
	output hazard_pkg::reg_addr_t exe_rs_b,
	output hazard_pkg::opcode_t   exe_opcode,
	output hazard_pkg::reg_addr_t exe_rd,
	output hazard_pkg::reg_addr_t mem_rd,
	output hazard_pkg::reg_addr_t wb_rd,
	output logic                  exe_wr_en,
	output logic                  mem_wr_en,
	output logic                  wb_wr_en,
	output hazard_pkg::sel_data_t exe_sel_data,
	output hazard_pkg::sel_data_t mem_sel_data,
	output hazard_pkg::sel_data_t wb_sel_data,
	output logic                  retire_valid,
	output hazard_pkg::reg_addr_t retire_rd
);
	import hazard_pkg::*;

	stage_state_t state;
	logic         stall_exe, stall_id, hold_id, take;
	logic         id_valid, exe_valid, mem_valid, wb_valid;
	reg_addr_t    id_rs_a_q, id_rs_b_q, id_rd_q, exe_rs_a_q, exe_rs_b_q;
	logic         id_wr_en_q, exe_wr_en_q, mem_wr_en_q, wb_wr_en_q;
	sel_data_t    id_sel_data_q;

	// Load in MEM feeding EXE takes priority over load feeding JALR
	assign stall_exe = (hzd_mem_to_exe_a || hzd_mem_to_exe_b) && (state != STALL_LD_EXE);
	assign stall_id  = hzd_exe_to_id_a && !stall_exe && (state != STALL_LD_JALR);
	assign hold_id   = stall_exe || stall_id;
	assign in_ready  = !hold_id;
	assign take      = in_valid && in_ready;

	// Control state and valid bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= RUN;
			id_valid     <= 1'b0;
			exe_valid    <= 1'b0;
			mem_valid    <= 1'b0;
			wb_valid     <= 1'b0;
			retire_valid <= 1'b0;
		end else begin
			if (stall_exe)
				state <= STALL_LD_EXE;
			else if (stall_id)
				state <= STALL_LD_JALR;
			else
				state <= RUN;
			// Empty input slot becomes a bubble in ID
			if (!hold_id)
				id_valid <= in_valid;
			// JALR stall holds ID and drops a bubble into EXE
			if (!stall_exe)
				exe_valid <= id_valid && !stall_id;
			mem_valid    <= exe_valid && !stall_exe;
			wb_valid     <= mem_valid;
			retire_valid <= wb_valid;
		end
	end

	// Stage payload, only meaningful under the valid bits
	always_ff @(posedge clk) begin
		if (take) begin
			id_rs_a_q     <= dec_rs_a;
			id_rs_b_q     <= dec_rs_b;
			id_rd_q       <= dec_rd;
			id_opcode     <= dec_opcode;
			id_wr_en_q    <= dec_wr_en;
			id_sel_op_a   <= dec_sel_op_a;
			id_sel_op_b   <= dec_sel_op_b;
			id_is_stype   <= dec_is_stype;
			id_sel_data_q <= dec_sel_data;
			id_imm_select <= dec_imm_select;
		end
		if (!stall_exe) begin
			exe_rs_a_q   <= id_rs_a_q;
			exe_rs_b_q   <= id_rs_b_q;
			exe_rd       <= id_rd_q;
			exe_opcode   <= id_opcode;
			exe_wr_en_q  <= id_wr_en_q;
			exe_sel_data <= id_sel_data_q;
		end
		mem_rd       <= exe_rd;
		mem_wr_en_q  <= exe_wr_en_q;
		mem_sel_data <= exe_sel_data;
		wb_rd        <= mem_rd;
		wb_wr_en_q   <= mem_wr_en_q;
		wb_sel_data  <= mem_sel_data;
		retire_rd    <= wb_rd;
	end

	// Empty consumer stages show x0 sources, so nothing matches them
	assign id_rs_a  = id_valid ? id_rs_a_q : '0;
	assign id_rs_b  = id_valid ? id_rs_b_q : '0;
	assign exe_rs_a = exe_valid ? exe_rs_a_q : '0;
	assign exe_rs_b = exe_valid ? exe_rs_b_q : '0;

	// Bubbles never produce a result
	assign exe_wr_en = exe_valid && exe_wr_en_q;
	assign mem_wr_en = mem_valid && mem_wr_en_q;
	assign wb_wr_en  = wb_valid && wb_wr_en_q;

	// Bubble behind a stall clears the hazard that caused it
	a_stall_single: assert property (@(posedge clk) disable iff (!arst_n)
		!((state == STALL_LD_EXE) && (hzd_mem_to_exe_a || hzd_mem_to_exe_b)) &&
		!((state == STALL_LD_JALR) && hzd_exe_to_id_a));

	a_id_held: assert property (@(posedge clk) disable iff (!arst_n)
		hold_id |=> $stable({id_rs_a_q, id_rs_b_q, id_rd_q, id_opcode, id_wr_en_q}));

	a_exe_held: assert property (@(posedge clk) disable iff (!arst_n)
		stall_exe |=> $stable({exe_rs_a_q, exe_rs_b_q, exe_rd, exe_opcode, exe_wr_en_q}));

	// Upstream keeps its word until accepted
	a_in_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(in_valid && !in_ready) |=> (in_valid && $stable(in_instr)));

endmodule

`default_nettype wire

/* pipe_hazard_top.f */
design/hazard_pkg.sv
design/inst_decode.sv
design/forwarding_unit.sv
design/stage_tracker.sv
design/pipe_hazard_top.sv
sim/tb_pipe_hazard.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f pipe_hazard_top.f \
	--top-module tb_pipe_hazard \
	-o sim_pipe_hazard

./obj_dir/sim_pipe_hazard | tee sim.log

if grep -qx "No errors" sim.log; then
	exit 0
fi
exit 1

/* sim/tb_pipe_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_hazard;
	import hazard_pkg::*;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	instr_t      in_instr;
	logic        in_ready;
	logic        fw_exe_to_id_a;
	logic        fw_exe_to_id_b;
	logic        fw_mem_to_id_a;
	logic        fw_mem_to_id_b;
	logic        fw_wb_to_id_a;
	logic        fw_wb_to_id_b;
	logic        fw_wb_to_exe_a;
	logic        fw_wb_to_exe_b;
	logic        hzd_exe_to_id_a;
	logic        hzd_mem_to_exe_a;
	logic        hzd_mem_to_exe_b;
	logic        retire_valid;
	reg_addr_t   retire_rd;
	logic [10:0] dut_flags;

	// Reference pipeline, index 0 is ID up to 3 for WB
	logic        m_valid [4];
	logic        m_wr [4];
	logic        m_ua [4];
	logic        m_ub [4];
	logic        m_load [4];
	opcode_t     m_op [4];
	reg_addr_t   m_rd [4];
	reg_addr_t   m_rs_a [4];
	reg_addr_t   m_rs_b [4];
	int          m_stalls [4];
	logic        r_valid;
	int          r_stalls;
	logic        prev_exe_stall;
	logic        prev_id_stall;
	logic        stall_exe_m;
	logic        stall_id_m;
	logic        exp_ready;
	logic [10:0] exp_flags;

	// Acceptance order for the retire check
	reg_addr_t   acc_rd_q [$];
	int          acc_cyc_q [$];

	// Run bookkeeping
	logic [31:0] lfsr;
	int          cyc;
	int          checks;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	logic        timed_out;
	string       test_name;
	logic [10:0] seen;
	int          first_seen [11];
	int          stall_cycles;

	// Bit 0 is fw_exe_to_id_a, bit 10 is hzd_mem_to_exe_b
	assign dut_flags = {hzd_mem_to_exe_b, hzd_mem_to_exe_a, hzd_exe_to_id_a,
		fw_wb_to_exe_b, fw_wb_to_exe_a, fw_wb_to_id_b, fw_wb_to_id_a,
		fw_mem_to_id_b, fw_mem_to_id_a, fw_exe_to_id_b, fw_exe_to_id_a};

	pipe_hazard_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic string flag_name(input int i);
		case (i)
			0:       return "fw_exe_to_id_a";
			1:       return "fw_exe_to_id_b";
			2:       return "fw_mem_to_id_a";
			3:       return "fw_mem_to_id_b";
			4:       return "fw_wb_to_id_a";
			5:       return "fw_wb_to_id_b";
			6:       return "fw_wb_to_exe_a";
			7:       return "fw_wb_to_exe_b";
			8:       return "hzd_exe_to_id_a";
			9:       return "hzd_mem_to_exe_a";
			default: return "hzd_mem_to_exe_b";
		endcase
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic random_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic opcode_t pick_opcode(input int idx);
		case (idx)
			0:       return OP_LUI;
			1:       return OP_AUIPC;
			2:       return OP_JAL;
			3:       return OP_JALR;
			4:       return OP_BRANCH;
			5:       return OP_LOAD;
			6:       return OP_STORE;
			7:       return OP_IMM;
			default: return OP_REG;
		endcase
	endfunction

	// Register fields at their RV32I positions, other bits zero
	function automatic instr_t enc(input opcode_t op, input reg_addr_t rd,
		input reg_addr_t rs1, input reg_addr_t rs2);
		return {7'b0, rs2, rs1, 3'b0, rd, op};
	endfunction

	// Architectural meaning of each opcode
	function automatic logic op_writes(input opcode_t op);
		return op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG};
	endfunction

	function automatic logic op_reads_rs1(input opcode_t op);
		return op inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_IMM, OP_REG};
	endfunction

	function automatic logic op_reads_rs2(input opcode_t op);
		return op inside {OP_BRANCH, OP_STORE, OP_REG};
	endfunction

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_rd(input string what, input reg_addr_t got, input reg_addr_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < 4; i++) begin
			m_valid[i] = 1'b0;
			m_stalls[i] = 0;
		end
		r_valid = 1'b0;
		r_stalls = 0;
		prev_exe_stall = 1'b0;
		prev_id_stall = 1'b0;
	endtask

	// Producer in stage p writes the nonzero source register
	function automatic logic src_match(input reg_addr_t src, input int p);
		return (src != '0) && m_valid[p] && m_wr[p] && (src == m_rd[p]);
	endfunction

	task automatic predict();
		logic ida, idb, exa, exb;
		ida = m_valid[0] && m_ua[0];
		idb = m_valid[0] && m_ub[0];
		exa = m_valid[1] && m_ua[1];
		exb = m_valid[1] && m_ub[1];
		// Load value does not exist yet while in EXE
		exp_flags[0] = ida && src_match(m_rs_a[0], 1) && !m_load[1];
		exp_flags[1] = idb && src_match(m_rs_b[0], 1) && !m_load[1];
		exp_flags[2] = ida && src_match(m_rs_a[0], 2);
		exp_flags[3] = idb && src_match(m_rs_b[0], 2);
		exp_flags[4] = ida && src_match(m_rs_a[0], 3);
		exp_flags[5] = idb && src_match(m_rs_b[0], 3);
		exp_flags[6] = exa && src_match(m_rs_a[1], 3) && m_load[3];
		exp_flags[7] = exb && src_match(m_rs_b[1], 3) && m_load[3];
		exp_flags[8] = m_valid[0] && (m_op[0] == OP_JALR) && src_match(m_rs_a[0], 1) &&
			m_load[1];
		exp_flags[9] = exa && src_match(m_rs_a[1], 2) && m_load[2];
		exp_flags[10] = exb && src_match(m_rs_b[1], 2) && m_load[2];
		// One cycle per stall kind, EXE stall wins
		stall_exe_m = (exp_flags[9] || exp_flags[10]) && !prev_exe_stall;
		stall_id_m = exp_flags[8] && !stall_exe_m && !prev_id_stall;
		exp_ready = !(stall_exe_m || stall_id_m);
	endtask

	task automatic copy_stage(input int f, input int t);
		m_valid[t] = m_valid[f];
		m_wr[t] = m_wr[f];
		m_ua[t] = m_ua[f];
		m_ub[t] = m_ub[f];
		m_load[t] = m_load[f];
		m_op[t] = m_op[f];
		m_rd[t] = m_rd[f];
		m_rs_a[t] = m_rs_a[f];
		m_rs_b[t] = m_rs_b[f];
		m_stalls[t] = m_stalls[f];
	endtask

	task automatic load_id(input instr_t w);
		m_valid[0] = 1'b1;
		m_op[0] = w[6:0];
		m_rd[0] = w[11:7];
		m_rs_a[0] = w[19:15];
		m_rs_b[0] = w[24:20];
		// x0 as destination writes nothing
		m_wr[0] = op_writes(w[6:0]) && (w[11:7] != '0);
		m_ua[0] = op_reads_rs1(w[6:0]);
		m_ub[0] = op_reads_rs2(w[6:0]);
		m_load[0] = (w[6:0] == OP_LOAD);
		m_stalls[0] = 0;
	endtask

	// Model state after the coming clock edge
	task automatic advance_model(input logic v, input instr_t w);
		logic hold;
		hold = stall_exe_m || stall_id_m;
		r_valid = m_valid[3];
		r_stalls = m_stalls[3];
		copy_stage(2, 3);
		if (stall_exe_m) begin
			// Consumer waits in EXE and a bubble goes to MEM
			m_valid[2] = 1'b0;
			m_stalls[1]++;
		end else begin
			copy_stage(1, 2);
			if (stall_id_m) begin
				m_valid[1] = 1'b0;
			end else begin
				copy_stage(0, 1);
			end
		end
		if (hold) begin
			m_stalls[0]++;
		end else if (v) begin
			load_id(w);
		end else begin
			m_valid[0] = 1'b0;
		end
		prev_exe_stall = stall_exe_m;
		prev_id_stall = stall_id_m;
	endtask

	task automatic compare_outputs();
		reg_addr_t front_rd;
		int        front_cyc;
		for (int i = 0; i < 11; i++) begin
			check_flag(flag_name(i), dut_flags[i], exp_flags[i]);
		end
		check_flag("in_ready", in_ready, exp_ready);
		check_flag("retire_valid", retire_valid, r_valid);
		if (retire_valid) begin
			if (acc_rd_q.size() == 0) begin
				$display("Retirement at %0t with no accepted instruction outstanding", $time);
				errors++;
				test_errors++;
			end else begin
				front_rd = acc_rd_q.pop_front();
				front_cyc = acc_cyc_q.pop_front();
				check_rd("retire_rd", retire_rd, front_rd);
				if (r_valid) begin
					check_count("retire latency", cyc - front_cyc, 4 + r_stalls);
				end
			end
		end
	endtask

	// Called 2 ns after a rising edge, samples 3 ns before the next one
	task automatic step_cycle(input logic v, input instr_t w, output logic accepted);
		in_valid = v;
		in_instr = w;
		#15;
		predict();
		compare_outputs();
		for (int i = 0; i < 11; i++) begin
			if (dut_flags[i] && !seen[i]) begin
				first_seen[i] = cyc;
			end
		end
		seen = seen | dut_flags;
		if (!in_ready) begin
			stall_cycles++;
		end
		accepted = v && exp_ready;
		// Acceptance edge is the next one, numbered cyc + 1
		if (accepted) begin
			acc_rd_q.push_back(w[11:7]);
			acc_cyc_q.push_back(cyc + 1);
		end
		advance_model(v, w);
		@(posedge clk);
		cyc++;
		#2;
	endtask

	task automatic send_word(input instr_t w);
		logic acc;
		int   tries;
		acc = 1'b0;
		tries = 0;
		while (!acc && !timed_out) begin
			step_cycle(1'b1, w, acc);
			tries++;
			if (!acc && tries >= 8) begin
				timed_out = 1'b1;
				$display("Timeout at %0t, word %h was never accepted", $time, w);
			end
		end
	endtask

	task automatic idle_cycle();
		logic acc;
		step_cycle(1'b0, '0, acc);
	endtask

	function automatic logic pipe_busy();
		return m_valid[0] || m_valid[1] || m_valid[2] || m_valid[3] || r_valid ||
			(acc_rd_q.size() != 0);
	endfunction

	task automatic drain_pipe();
		int n;
		n = 0;
		while (pipe_busy() && !timed_out) begin
			idle_cycle();
			n++;
			if (n >= 16 && pipe_busy()) begin
				timed_out = 1'b1;
				$display("Timeout at %0t, pipeline did not empty", $time);
			end
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		seen = '0;
		stall_cycles = 0;
		for (int i = 0; i < 11; i++) begin
			first_seen[i] = -1;
		end
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: %0d mismatches", test_name, test_errors);
		end
	endtask

	task automatic test_alu_forward();
		begin_test("alu_forward_distance");
		// Back to back on both operands
		send_word(enc(OP_REG, 5'd1, 5'd2, 5'd3));
		send_word(enc(OP_REG, 5'd2, 5'd1, 5'd1));
		drain_pipe();
		// One LUI x0 in between
		send_word(enc(OP_REG, 5'd1, 5'd2, 5'd3));
		send_word(enc(OP_LUI, 5'd0, 5'd0, 5'd0));
		send_word(enc(OP_REG, 5'd3, 5'd1, 5'd0));
		drain_pipe();
		// Two in between
		send_word(enc(OP_REG, 5'd1, 5'd2, 5'd3));
		send_word(enc(OP_LUI, 5'd0, 5'd0, 5'd0));
		send_word(enc(OP_LUI, 5'd0, 5'd0, 5'd0));
		send_word(enc(OP_REG, 5'd3, 5'd0, 5'd1));
		drain_pipe();
		check_flag("seen fw_exe_to_id_a", seen[0], 1'b1);
		check_flag("seen fw_exe_to_id_b", seen[1], 1'b1);
		check_flag("seen fw_mem_to_id_a", seen[2], 1'b1);
		check_flag("seen fw_wb_to_id_b", seen[5], 1'b1);
		end_test();
	endtask

	task automatic test_load_use();
		begin_test("load_then_reg");
		send_word(enc(OP_LOAD, 5'd1, 5'd2, 5'd0));
		send_word(enc(OP_REG, 5'd2, 5'd1, 5'd3));
		drain_pipe();
		check_count("stall cycles", stall_cycles, 1);
		check_flag("seen hzd_mem_to_exe_a", seen[9], 1'b1);
		check_flag("seen fw_wb_to_exe_a", seen[6], 1'b1);
		check_flag("seen fw_exe_to_id_a", seen[0], 1'b0);
		check_count("cycles from hazard to WB forward", first_seen[6] - first_seen[9], 1);
		end_test();
	endtask

	task automatic test_load_jalr();
		begin_test("load_then_jalr");
		send_word(enc(OP_LOAD, 5'd1, 5'd2, 5'd0));
		send_word(enc(OP_JALR, 5'd2, 5'd1, 5'd0));
		drain_pipe();
		check_count("stall cycles", stall_cycles, 1);
		check_flag("seen hzd_exe_to_id_a", seen[8], 1'b1);
		check_flag("seen fw_exe_to_id_a", seen[0], 1'b0);
		end_test();
	endtask

	task automatic test_no_forward();
		begin_test("x0_and_unused_operands");
		// Writes to x0 are dropped and x0 reads never match
		send_word(enc(OP_REG, 5'd0, 5'd1, 5'd2));
		send_word(enc(OP_REG, 5'd3, 5'd0, 5'd0));
		drain_pipe();
		// U and J formats carry immediate bits in the rs fields
		send_word(enc(OP_REG, 5'd1, 5'd2, 5'd3));
		send_word(enc(OP_LUI, 5'd2, 5'd1, 5'd1));
		send_word(enc(OP_AUIPC, 5'd3, 5'd1, 5'd1));
		send_word(enc(OP_JAL, 5'd2, 5'd1, 5'd1));
		// I type has no rs2 even when the field matches
		send_word(enc(OP_REG, 5'd1, 5'd0, 5'd0));
		send_word(enc(OP_IMM, 5'd3, 5'd0, 5'd1));
		drain_pipe();
		check_flag("any forward or hazard flag", |seen, 1'b0);
		end_test();
	endtask

	task automatic test_random();
		logic [31:0] bits;
		opcode_t     op;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		begin_test("random_stream");
		for (int i = 0; i < 2000 && !timed_out; i++) begin
			// A quarter of the words come after an empty cycle
			random_bits(2, bits);
			if (bits[1:0] == 2'b00) begin
				idle_cycle();
			end
			random_bits(4, bits);
			op = pick_opcode(int'(bits[3:0]) % 9);
			// Only x0 to x3 so hazards are frequent
			random_bits(2, bits);
			rd = {3'b000, bits[1:0]};
			random_bits(2, bits);
			rs1 = {3'b000, bits[1:0]};
			random_bits(2, bits);
			rs2 = {3'b000, bits[1:0]};
			send_word(enc(op, rd, rs1, rs2));
		end
		drain_pipe();
		end_test();
	endtask

	initial begin
		lfsr = 32'he68f1be9;
		cyc = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		reset_model();
		repeat (3) @(posedge clk);
		#2;
		arst_n = 1'b1;

		test_alu_forward();
		if (!timed_out) begin
			test_load_use();
		end
		if (!timed_out) begin
			test_load_jalr();
		end
		if (!timed_out) begin
			test_no_forward();
		end
		if (!timed_out) begin
			test_random();
		end

		$display("tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
			tests_run, tests_failed, checks, errors);
		if (timed_out || errors != 0) begin
			$display("Errors found");
		end else begin
			$display("No errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
